// ==== hw/cache_params.svh ====
// cache and memory parameters
//   address field widths and word width
//   line size in words
//   bank busy time and read latency of the main memory
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address and data word
`define ADDR_W      16
`define DATA_W      16

// address split into tag, set index and byte offset
`define TAG_W       5
`define INDEX_W     8
`define OFFSET_W    3

// words per line, also the number of memory banks
`define LINE_WORDS  4

// memory timing in cycles
`define BANK_BUSY   4
`define MEM_RD_LAT  2

`endif

// ==== hw/cache_pkg.sv ====
// shared cache types
//   address, word and address field types
//   controller state encoding
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

   typedef logic [`ADDR_W-1:0]   addr_t;
   typedef logic [`DATA_W-1:0]   word_t;
   typedef logic [`TAG_W-1:0]    tag_t;
   typedef logic [`INDEX_W-1:0]  index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   // write-back and fill states are consecutive so the FSM can step by one
   typedef enum logic [3:0]
   {
      idle,
      lookup_rd,
      lookup_wr,
      wb_0,
      wb_1,
      wb_2,
      wb_3,
      fill_rd_0,
      fill_rd_1,
      fill_rd_2_wr_0,
      fill_rd_3_wr_1,
      fill_wr_2,
      fill_wr_3,
      write_after_fill,
      done_miss,
      done_hit
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/cache_way.sv ====
// one way of the set-associative cache
//   per-set valid, dirty and tag storage
//   four data words per set
//   tag compare and compare or fill writes
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_way
(
   input  logic              clk,
   input  logic              rst,
   input  cache_pkg::index_t index,
   input  cache_pkg::tag_t   tag_in,
   input  logic [1:0]        word_sel,
   input  cache_pkg::word_t  data_in,
   input  logic              comp,
   input  logic              write,
   output cache_pkg::word_t  data_out,
   output cache_pkg::tag_t   tag_out,
   output logic              hit,
   output logic              valid,
   output logic              dirty
);
   import cache_pkg::*;

   localparam int SETS = 1 << `INDEX_W;

   logic  valid_arr [SETS];
   logic  dirty_arr [SETS];
   tag_t  tag_arr [SETS];
   word_t data_arr [SETS * `LINE_WORDS];

   logic [`INDEX_W+1:0] word_addr;
   logic                store;

   assign word_addr = {index, word_sel};

   // compare writes need a matching tag, fill writes always go in
   assign store = write & (~comp | hit);

   assign data_out = data_arr[word_addr];
   assign tag_out  = tag_arr[index];
   assign valid    = valid_arr[index];
   assign dirty    = dirty_arr[index];
   assign hit      = valid_arr[index] && (tag_arr[index] == tag_in);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < SETS; i++)
         begin
            valid_arr[i] <= 1'b0;
            dirty_arr[i] <= 1'b0;
         end
      end
      else if (store)
      begin
         valid_arr[index] <= 1'b1;
         // dirty on a requester write, clean after a fill
         dirty_arr[index] <= comp;
      end
   end

   always_ff @(posedge clk)
   begin
      if (store)
         data_arr[word_addr] <= data_in;
      if (write && !comp)
         tag_arr[index] <= tag_in;
   end

endmodule

`default_nettype wire

// ==== hw/way_select.sv ====
// way selection for the two-way cache
//   hit combining and victim bit
//   way choice register and write strobes
//   tag and data multiplexers
`timescale 1ns/1ps
`default_nettype none

module way_select
(
   input  logic             clk,
   input  logic             rst,
   input  logic             hit_0,
   input  logic             hit_1,
   input  logic             valid_0,
   input  logic             valid_1,
   input  logic             dirty_0,
   input  logic             dirty_1,
   input  cache_pkg::tag_t  tag_0,
   input  cache_pkg::tag_t  tag_1,
   input  cache_pkg::word_t data_0,
   input  cache_pkg::word_t data_1,
   input  logic             lookup,
   input  logic             write_en,
   output logic             any_hit,
   output logic             victim_dirty,
   output cache_pkg::tag_t  sel_tag,
   output cache_pkg::word_t sel_data,
   output logic             write_0,
   output logic             write_1
);
   logic victim_q;
   logic choice_q;
   logic choice_now;
   logic way_pick;
   logic sel_way;

   // empty ways are filled first, then the victim bit decides
   assign choice_now = (valid_0 & valid_1) ? victim_q : valid_0;

   // the choice is live in lookup and held for the rest of the miss
   assign way_pick = lookup ? choice_now : choice_q;

   // a hit overrides the choice, way 1 wins a double hit
   assign sel_way = hit_1 | (~hit_0 & way_pick);

   assign any_hit      = hit_0 | hit_1;
   assign victim_dirty = sel_way ? dirty_1 : dirty_0;
   assign sel_tag      = sel_way ? tag_1 : tag_0;
   assign sel_data     = sel_way ? data_1 : data_0;
   assign write_0      = write_en & ~sel_way;
   assign write_1      = write_en & sel_way;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         victim_q <= 1'b0;
         choice_q <= 1'b0;
      end
      else if (lookup)
      begin
         victim_q <= ~victim_q;
         choice_q <= choice_now;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
// cache controller FSM
//   lookup of reads and writes
//   dirty victim write-back and four-word line fill
//   done, stall and hit status
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_ctrl
(
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   input  logic             any_hit,
   input  logic             victim_dirty,
   input  cache_pkg::tag_t  sel_tag,
   input  cache_pkg::word_t sel_data,
   input  logic             mem_stall,
   input  cache_pkg::word_t mem_rd_data,
   output logic             comp,
   output logic             write_en,
   output logic             lookup,
   output logic [1:0]       word_sel,
   output cache_pkg::word_t way_data,
   output cache_pkg::addr_t mem_addr,
   output logic             mem_rd,
   output logic             mem_wr,
   output cache_pkg::word_t mem_wr_data,
   output logic             done,
   output logic             stall,
   output logic             cache_hit
);
   import cache_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;
   ctrl_state_t start_state;
   tag_t        req_tag;
   index_t      req_index;
   offset_t     req_offset;
   tag_t        mem_tag;
   logic [1:0]  mem_word;
   logic [1:0]  wb_word;
   logic [1:0]  rd_word;
   logic [1:0]  fill_word;
   logic        fill_sel;

   assign req_tag    = addr[`ADDR_W-1 -: `TAG_W];
   assign req_index  = addr[`OFFSET_W +: `INDEX_W];
   assign req_offset = addr[`OFFSET_W-1:0];

   // word position within each state sequence
   assign wb_word   = 2'(state - wb_0);
   assign rd_word   = 2'(state - fill_rd_0);
   assign fill_word = 2'(state - fill_rd_2_wr_0);

   assign mem_addr    = {mem_tag, req_index, mem_word, 1'b0};
   assign mem_wr_data = sel_data;
   assign way_data    = fill_sel ? mem_rd_data : data_in;

   always_comb
   begin
      if (rd && !wr)
         start_state = lookup_rd;
      else if (wr && !rd)
         start_state = lookup_wr;
      else
         start_state = idle;
   end

   always_comb
   begin
      next_state = state;
      comp       = 1'b0;
      write_en   = 1'b0;
      lookup     = 1'b0;
      word_sel   = req_offset[`OFFSET_W-1:1];
      fill_sel   = 1'b0;
      mem_tag    = req_tag;
      mem_word   = 2'd0;
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      done       = 1'b0;
      stall      = 1'b1;
      cache_hit  = 1'b0;
      case (state)
         idle:
         begin
            stall      = 1'b0;
            next_state = start_state;
         end
         lookup_rd, lookup_wr:
         begin
            lookup   = 1'b1;
            comp     = 1'b1;
            write_en = (state == lookup_wr);
            if (any_hit)
            begin
               // read hits finish here, write hits one cycle later
               done       = (state == lookup_rd);
               cache_hit  = (state == lookup_rd);
               next_state = (state == lookup_rd) ? idle : done_hit;
            end
            else
               next_state = victim_dirty ? wb_0 : fill_rd_0;
         end
         wb_0, wb_1, wb_2, wb_3:
         begin
            mem_wr   = 1'b1;
            mem_tag  = sel_tag;
            mem_word = wb_word;
            word_sel = wb_word;
            if (!mem_stall)
               next_state = ctrl_state_t'(state + 4'd1);
         end
         fill_rd_0, fill_rd_1, fill_rd_2_wr_0, fill_rd_3_wr_1:
         begin
            mem_rd   = 1'b1;
            mem_word = rd_word;
            if (!mem_stall)
               next_state = ctrl_state_t'(state + 4'd1);
         end
         fill_wr_2:
            next_state = fill_wr_3;
         fill_wr_3:
            next_state = wr ? write_after_fill : done_miss;
         write_after_fill:
         begin
            comp       = 1'b1;
            write_en   = 1'b1;
            next_state = done_miss;
         end
         done_miss:
         begin
            done       = 1'b1;
            stall      = 1'b0;
            next_state = start_state;
         end
         done_hit:
         begin
            done       = 1'b1;
            stall      = 1'b0;
            cache_hit  = 1'b1;
            next_state = start_state;
         end
      endcase

      // fill writes trail the memory reads by two states
      if (state inside {fill_rd_2_wr_0, fill_rd_3_wr_1, fill_wr_2, fill_wr_3})
      begin
         write_en = 1'b1;
         fill_sel = 1'b1;
         word_sel = fill_word;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= idle;
      else
         state <= next_state;
   end

endmodule

`default_nettype wire

// ==== hw/banked_mem.sv ====
// four-bank main memory
//   word array shared by the banks
//   busy countdown per bank and stall
//   pipelined read data
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module banked_mem
(
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t wr_data,
   input  logic             rd,
   input  logic             wr,
   output cache_pkg::word_t rd_data,
   output logic             stall
);
   import cache_pkg::*;

   localparam int WORDS = 1 << (`ADDR_W - 1);
   localparam int CNT_W = $clog2(`BANK_BUSY + 1);

   word_t              mem [WORDS];
   word_t              rd_pipe [`MEM_RD_LAT];
   logic [CNT_W-1:0]   busy_cnt [`LINE_WORDS];
   logic [`ADDR_W-2:0] word_addr;
   logic [1:0]         bank;
   logic               accept;

   assign word_addr = addr[`ADDR_W-1:1];
   // banks interleave on the word offset
   assign bank      = addr[2:1];
   assign stall     = (rd | wr) & (busy_cnt[bank] != '0);
   assign accept    = (rd | wr) & ~stall;
   assign rd_data   = rd_pipe[`MEM_RD_LAT-1];

   initial
   begin
      for (int i = 0; i < WORDS; i++)
         mem[i] = '0;
   end

   always @(posedge clk)
   begin
      if (accept && wr)
         mem[word_addr] <= wr_data;
   end

   // a bank stays busy for BANK_BUSY cycles counting the access cycle
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < `LINE_WORDS; b++)
      begin
         if (rst)
            busy_cnt[b] <= '0;
         else if (accept && (bank == 2'(b)))
            busy_cnt[b] <= CNT_W'(`BANK_BUSY - 1);
         else if (busy_cnt[b] != '0)
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept && rd)
         rd_pipe[0] <= mem[word_addr];
      for (int s = 1; s < `MEM_RD_LAT; s++)
         rd_pipe[s] <= rd_pipe[s-1];
   end

endmodule

`default_nettype wire

// ==== hw/mem_system.sv ====
// cached memory system top level
//   controller FSM and two cache ways
//   way selector driving the read data
//   banked main memory
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module mem_system
(
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   output cache_pkg::word_t data_out,
   output logic             done,
   output logic             stall,
   output logic             cache_hit
);
   import cache_pkg::*;

   logic       comp;
   logic       write_en;
   logic       lookup;
   logic [1:0] word_sel;
   word_t      way_data;
   logic       hit_0;
   logic       hit_1;
   logic       valid_0;
   logic       valid_1;
   logic       dirty_0;
   logic       dirty_1;
   tag_t       tag_0;
   tag_t       tag_1;
   word_t      data_0;
   word_t      data_1;
   logic       write_0;
   logic       write_1;
   logic       any_hit;
   logic       victim_dirty;
   tag_t       sel_tag;
   addr_t      mem_addr;
   logic       mem_rd;
   logic       mem_wr;
   logic       mem_stall;
   word_t      mem_wr_data;
   word_t      mem_rd_data;

   cache_ctrl u_ctrl (.clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .any_hit(any_hit), .victim_dirty(victim_dirty), .sel_tag(sel_tag), .sel_data(data_out),
      .mem_stall(mem_stall), .mem_rd_data(mem_rd_data), .comp(comp), .write_en(write_en),
      .lookup(lookup), .word_sel(word_sel), .way_data(way_data), .mem_addr(mem_addr),
      .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_wr_data(mem_wr_data), .done(done),
      .stall(stall), .cache_hit(cache_hit));

   cache_way u_way_0 (.clk(clk), .rst(rst), .index(addr[`OFFSET_W +: `INDEX_W]),
      .tag_in(addr[`ADDR_W-1 -: `TAG_W]), .word_sel(word_sel), .data_in(way_data),
      .comp(comp), .write(write_0), .data_out(data_0), .tag_out(tag_0), .hit(hit_0),
      .valid(valid_0), .dirty(dirty_0));

   cache_way u_way_1 (.clk(clk), .rst(rst), .index(addr[`OFFSET_W +: `INDEX_W]),
      .tag_in(addr[`ADDR_W-1 -: `TAG_W]), .word_sel(word_sel), .data_in(way_data),
      .comp(comp), .write(write_1), .data_out(data_1), .tag_out(tag_1), .hit(hit_1),
      .valid(valid_1), .dirty(dirty_1));

   way_select u_sel (.clk(clk), .rst(rst), .hit_0(hit_0), .hit_1(hit_1), .valid_0(valid_0),
      .valid_1(valid_1), .dirty_0(dirty_0), .dirty_1(dirty_1), .tag_0(tag_0), .tag_1(tag_1),
      .data_0(data_0), .data_1(data_1), .lookup(lookup), .write_en(write_en),
      .any_hit(any_hit), .victim_dirty(victim_dirty), .sel_tag(sel_tag), .sel_data(data_out),
      .write_0(write_0), .write_1(write_1));

   banked_mem u_mem (.clk(clk), .rst(rst), .addr(mem_addr), .wr_data(mem_wr_data),
      .rd(mem_rd), .wr(mem_wr), .rd_data(mem_rd_data), .stall(mem_stall));

endmodule

`default_nettype wire

// ==== verif/tb_mem_system.sv ====
// testbench for the cached memory system
//   directed and random request table
//   behavioral cache model with data, hit and timing checks
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

   localparam int N_DIRECTED = 14;
   localparam int N_RANDOM   = 24;
   localparam int N_ENTRIES  = N_DIRECTED + N_RANDOM;
   localparam int MAX_CYCLES = 60 * N_ENTRIES;

   logic        clk;
   logic        rst;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;

   // request table with a hit of -1 where the model alone decides
   logic        tab_wr [N_ENTRIES];
   logic [15:0] tab_addr [N_ENTRIES];
   logic [15:0] tab_data [N_ENTRIES];
   int          tab_hit [N_ENTRIES];
   int          n_tab;

   // reference model state
   logic [15:0] model_mem [32768];
   logic        m_valid [2][256];
   logic [4:0]  m_tag [2][256];
   logic        m_victim;

   int data_errs;
   int hit_errs;
   int timing_errs;
   int cycle_cnt;

   mem_system UUT (.clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit));

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: no done from the DUT after %0d cycles", cycle_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [7:0] idx,
                                             input logic [1:0] word);
      return {tag, idx, word, 1'b0};
   endfunction

   task automatic add_entry(input logic is_wr, input logic [15:0] a, input logic [15:0] d,
                            input int hit);
      tab_wr[n_tab]   = is_wr;
      tab_addr[n_tab] = a;
      tab_data[n_tab] = d;
      tab_hit[n_tab]  = hit;
      n_tab++;
   endtask

   // two-way lookup with empty way first and the global victim bit after
   task automatic predict_access(input logic is_wr, input logic [15:0] a,
                                 input logic [15:0] d, output logic hit,
                                 output logic [15:0] rdata);
      logic [4:0] tag;
      logic [7:0] idx;
      int         way;
      tag = a[15:11];
      idx = a[10:3];
      hit = m_valid[0][idx] && (m_tag[0][idx] == tag) ||
            m_valid[1][idx] && (m_tag[1][idx] == tag);
      if (!hit)
      begin
         if (m_valid[0][idx] && m_valid[1][idx])
            way = int'(m_victim);
         else
            way = m_valid[0][idx] ? 1 : 0;
         m_valid[way][idx] = 1'b1;
         m_tag[way][idx]   = tag;
      end
      m_victim = ~m_victim;
      if (is_wr)
         model_mem[a[15:1]] = d;
      rdata = model_mem[a[15:1]];
   endtask

   task automatic apply_entry(input int i);
      logic        exp_hit;
      logic [15:0] exp_data;
      int          waited;
      predict_access(tab_wr[i], tab_addr[i], tab_data[i], exp_hit, exp_data);
      addr    = tab_addr[i];
      data_in = tab_data[i];
      rd      = ~tab_wr[i];
      wr      = tab_wr[i];
      waited  = 0;
      do
      begin
         @(negedge clk);
         waited++;
         if (!done)
            assert (stall) else
            begin
               timing_errs++;
               $display("mismatch at %0t: entry %0d stall low before done", $time, i);
            end
      end while (!done);
      assert (cache_hit == exp_hit && (tab_hit[i] < 0 || tab_hit[i] == int'(exp_hit))) else
      begin
         hit_errs++;
         $display("mismatch at %0t: entry %0d cache_hit %0b model %0b table %0d",
                  $time, i, cache_hit, exp_hit, tab_hit[i]);
      end
      if (!tab_wr[i])
         assert (data_out == exp_data) else
         begin
            data_errs++;
            $display("mismatch at %0t: entry %0d addr %h data_out %h expected %h",
                     $time, i, tab_addr[i], data_out, exp_data);
         end
      if (exp_hit)
         assert (waited == (tab_wr[i] ? 2 : 1)) else
         begin
            timing_errs++;
            $display("mismatch at %0t: entry %0d hit took %0d cycles", $time, i, waited);
         end
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      // done is a single cycle pulse
      assert (!done) else
      begin
         timing_errs++;
         $display("mismatch at %0t: entry %0d done longer than one cycle", $time, i);
      end
   endtask

   initial
   begin
      logic [4:0] rand_tags [3];
      void'($urandom(66));
      rst = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      cycle_cnt = 0;
      data_errs = 0;
      hit_errs = 0;
      timing_errs = 0;
      n_tab = 0;
      m_victim = 1'b0;
      for (int i = 0; i < 32768; i++)
         model_mem[i] = '0;
      for (int i = 0; i < 256; i++)
      begin
         m_valid[0][i] = 1'b0;
         m_valid[1][i] = 1'b0;
      end

      // cold miss, repeat hit, write miss and hits, other words of a line
      add_entry(1'b0, make_addr(5'd1, 8'd5, 2'd0), 16'h0000, 0);
      add_entry(1'b0, make_addr(5'd1, 8'd5, 2'd0), 16'h0000, 1);
      add_entry(1'b1, make_addr(5'd2, 8'd6, 2'd1), 16'h1234, 0);
      add_entry(1'b0, make_addr(5'd2, 8'd6, 2'd1), 16'h0000, 1);
      add_entry(1'b1, make_addr(5'd2, 8'd6, 2'd1), 16'h5678, 1);
      add_entry(1'b0, make_addr(5'd2, 8'd6, 2'd3), 16'h0000, 1);
      add_entry(1'b0, make_addr(5'd2, 8'd6, 2'd2), 16'h0000, 1);
      // three tags on index 9 force dirty evictions
      add_entry(1'b1, make_addr(5'd3, 8'd9, 2'd0), 16'haaaa, 0);
      add_entry(1'b1, make_addr(5'd4, 8'd9, 2'd1), 16'hbbbb, 0);
      add_entry(1'b1, make_addr(5'd5, 8'd9, 2'd2), 16'hcccc, 0);
      add_entry(1'b0, make_addr(5'd4, 8'd9, 2'd1), 16'h0000, 0);
      add_entry(1'b0, make_addr(5'd3, 8'd9, 2'd0), 16'h0000, 0);
      add_entry(1'b0, make_addr(5'd5, 8'd9, 2'd2), 16'h0000, 0);
      add_entry(1'b0, make_addr(5'd3, 8'd9, 2'd0), 16'h0000, 1);

      rand_tags[0] = 5'd7;
      rand_tags[1] = 5'd11;
      rand_tags[2] = 5'd19;
      for (int i = 0; i < N_RANDOM; i++)
         add_entry(1'($urandom_range(1, 0)),
                   make_addr(rand_tags[$urandom_range(2, 0)], 8'(20 + $urandom_range(2, 0)),
                             2'($urandom_range(3, 0))),
                   16'($urandom), -1);

      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // quiet outputs with no request
      repeat (5)
      begin
         @(negedge clk);
         assert (!done && !stall && !cache_hit) else
         begin
            timing_errs++;
            $display("mismatch at %0t: status high while idle", $time);
         end
      end

      for (int i = 0; i < n_tab; i++)
         apply_entry(i);

      $display("errors: data %0d, hit %0d, timing %0d", data_errs, hit_errs, timing_errs);
      if (data_errs + hit_errs + timing_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_ctrl.sv
hw/banked_mem.sv
hw/mem_system.sv
verif/tb_mem_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cached memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_mem_system -o tb_mem_system
sim_out=$(./obj_dir/tb_mem_system)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
